// File: include/mb_config.svh
// ----------------------------------------------------------
// Board-level sizes for the 8088 motherboard glue logic
// Address map assumes a 20-bit bus and ROM in the top 64 KB
// RAM decode covers four banks below 256 KB only
// ----------------------------------------------------------
`ifndef MB_CONFIG_SVH
`define MB_CONFIG_SVH

// Bus widths
`define MB_ADDR_W      20
`define MB_DMA_ADDR_W  16
`define MB_DATA_W      8
`define MB_PAGE_W      4

// Port groups and DMA channels
`define MB_IO_CS_W     4   // dma, intr, timer, ppi
`define MB_DMA_CHANS   4

// Memory regions
`define MB_NUM_BANKS   4
`define MB_ROM_SELS    8
`define MB_ROM_SEGMENT 4'hF   // top nibble of ROM space

`endif

// File: design/mb_pkg.sv
// ----------------------------------------------------------
// Bus types and port-group encoding shared by the glue logic
// Port groups are valid only with address bits 9 and 8 zero
// ----------------------------------------------------------
`default_nettype none

`include "mb_config.svh"

package mb_pkg;

   typedef logic [`MB_ADDR_W-1:0]    mb_addr_t;
   typedef logic [`MB_DATA_W-1:0]    mb_data_t;
   typedef logic [`MB_PAGE_W-1:0]    mb_page_t;
   typedef logic [`MB_NUM_BANKS-1:0] mb_bank_t;   // One bit per RAM bank

   // Decoded from address bits 7 to 5
   typedef enum logic [2:0] {
      port_dma      = 3'd0,
      port_intr     = 3'd1,
      port_timer    = 3'd2,
      port_ppi      = 3'd3,
      port_page     = 3'd4,
      port_nmi_mask = 3'd5,
      port_none     = 3'd6   // groups 6 and 7 both land here
   } mb_port_grp_e;

endpackage

`default_nettype wire

// File: design/mb_sys_bus_if.sv
// ----------------------------------------------------------
// Formed system bus cycle, one cycle behind the CPU/DMA pins
// Commands are active high here, unlike the board pins
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface mb_sys_bus_if;
   import mb_pkg::*;

   mb_addr_t addr;
   logic     aen;       // DMA owns the bus
   logic     ior;
   logic     iow;
   logic     memr;
   logic     memw;
   logic     refresh;   // Channel 0 acknowledged

   modport source (
      output addr, aen, ior, iow, memr, memw, refresh
   );

   modport sink (
      input addr, aen, ior, iow, memr, memw, refresh
   );

endinterface

`default_nettype wire

// File: design/mb_addr_former.sv
// ----------------------------------------------------------
// Latches the CPU address on ALE or forms the DMA address
// from the page register; all bus outputs are registered
// Page entry of the lowest active dack wins, entry 0 if none
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mb_config.svh"

module mb_addr_former (
   input  logic                      clk,
   input  logic                      reset_n,
   input  mb_pkg::mb_addr_t          cpu_addr_i,
   input  logic                      ale_i,
   input  logic [`MB_DMA_ADDR_W-1:0] dma_addr_i,
   input  logic [`MB_DMA_CHANS-1:0]  dack_n_i,
   input  logic                      ior_n_i,
   input  logic                      iow_n_i,
   input  logic                      memr_n_i,
   input  logic                      memw_n_i,
   input  mb_pkg::mb_data_t          data_i,
   input  logic                      page_wr_i,
   input  logic                      aen_brd_i,
   input  logic                      dma_aen_i,
   mb_sys_bus_if.source              bus_o
);
   import mb_pkg::*;

   mb_page_t   page_q [`MB_DMA_CHANS];
   logic [1:0] page_sel;
   mb_addr_t   addr_q;

   // Lowest-numbered acknowledged channel picks the page
   always_comb begin
      page_sel = '0;
      for (int i = `MB_DMA_CHANS - 1; i >= 0; i--) begin
         if (!dack_n_i[i])
            page_sel = 2'(i);
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `MB_DMA_CHANS; i++)
            page_q[i] <= '0;
      end else if (page_wr_i) begin
         page_q[addr_q[1:0]] <= data_i[`MB_PAGE_W-1:0];   // Port offset picks entry
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         addr_q       <= '1;   // Decodes to no port and no RAM
         bus_o.aen    <= 1'b0;
         bus_o.ior    <= 1'b0;
         bus_o.iow    <= 1'b0;
         bus_o.memr   <= 1'b0;
         bus_o.memw   <= 1'b0;
         bus_o.refresh <= 1'b0;
      end else begin
         if (dma_aen_i)
            addr_q <= {page_q[page_sel], dma_addr_i};
         else if (ale_i)
            addr_q <= cpu_addr_i;
         bus_o.aen     <= aen_brd_i;
         bus_o.ior     <= ~ior_n_i;
         bus_o.iow     <= ~iow_n_i;
         bus_o.memr    <= ~memr_n_i;
         bus_o.memw    <= ~memw_n_i;
         bus_o.refresh <= ~dack_n_i[0];
      end
   end

   assign bus_o.addr = addr_q;

   // CPU must not strobe an address once DMA drives the bus
   a_no_ale_in_dma: assert property (@(posedge clk) disable iff (!reset_n)
      !(ale_i && dma_aen_i));

endmodule

`default_nettype wire

// File: design/mb_io_decoder.sv
// ----------------------------------------------------------
// Port decoder for the lower 1 KB of I/O space
// Chip selects ignore the command, as the board's 74LS138 does
// Everything is blocked while DMA owns the bus
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mb_config.svh"

module mb_io_decoder (
   mb_sys_bus_if.sink              bus_i,
   output logic [`MB_IO_CS_W-1:0]  io_cs_n_o,
   output logic                    page_wr_o,
   output logic                    nmi_mask_wr_o
);
   import mb_pkg::*;

   mb_port_grp_e grp;

   always_comb begin
      grp = port_none;
      if (bus_i.addr[9:8] == 2'b00 && !bus_i.aen) begin
         case (bus_i.addr[7:5])
            3'd0:    grp = port_dma;
            3'd1:    grp = port_intr;
            3'd2:    grp = port_timer;
            3'd3:    grp = port_ppi;
            3'd4:    grp = port_page;
            3'd5:    grp = port_nmi_mask;
            default: grp = port_none;
         endcase
      end
   end

   assign io_cs_n_o[0] = (grp != port_dma);
   assign io_cs_n_o[1] = (grp != port_intr);
   assign io_cs_n_o[2] = (grp != port_timer);
   assign io_cs_n_o[3] = (grp != port_ppi);

   // Register writes on the board itself
   assign page_wr_o     = (grp == port_page) && bus_i.iow;
   assign nmi_mask_wr_o = (grp == port_nmi_mask) && bus_i.iow;

   // A port cycle is never a read and a write at once
   always_comb begin
      a_one_cmd: assert final ($onehot0({bus_i.ior, bus_i.iow}));
   end

endmodule

`default_nettype wire

// File: design/mb_mem_decoder.sv
// ----------------------------------------------------------
// ROM selects, RAM RAS/CAS and the row/column address switch
// A single register replaces the board's delay line
// RAM decode is limited to 256 KB in four 64 KB banks
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mb_config.svh"

module mb_mem_decoder (
   input  logic                     clk,
   input  logic                     reset_n,
   mb_sys_bus_if.sink               bus_i,
   output logic [`MB_ROM_SELS-1:0]  rom_cs_n_o,
   output mb_pkg::mb_bank_t         ras_n_o,
   output mb_pkg::mb_bank_t         cas_n_o,
   output logic                     addr_sel_o
);
   import mb_pkg::*;

   logic     rom_rd;
   logic     ram_hit;
   logic     rasc;      // Any memory command
   logic     ram_cyc;   // Normal RAM access, not refresh
   logic     dly_q;
   mb_bank_t bank_sel;

   assign rom_rd  = bus_i.memr && (bus_i.addr[19:16] == `MB_ROM_SEGMENT);
   assign ram_hit = (bus_i.addr[19:18] == 2'b00);
   assign rasc    = bus_i.memr || bus_i.memw;
   assign ram_cyc = rasc && ram_hit && !bus_i.refresh;

   assign bank_sel = mb_bank_t'(1) << bus_i.addr[17:16];

   // One 8 KB ROM socket per select
   assign rom_cs_n_o = rom_rd ? ~(`MB_ROM_SELS'(1) << bus_i.addr[15:13]) : '1;

   always_comb begin
      if (bus_i.memr && bus_i.refresh)
         ras_n_o = '0;   // Refresh strobes every bank
      else if (ram_cyc)
         ras_n_o = ~bank_sel;
      else
         ras_n_o = '1;
   end

   // Stands in for the delay tap after RAS
   always_ff @(posedge clk) begin
      if (!reset_n)
         dly_q <= 1'b0;
      else
         dly_q <= ram_cyc;
   end

   assign addr_sel_o = dly_q && ram_cyc;   // Switch to column address
   assign cas_n_o    = (dly_q && ram_cyc) ? ~bank_sel : '1;

   // Several rows open at once only when DMA channel 0 refreshes
   a_multi_ras_refresh: assert property (@(posedge clk) disable iff (!reset_n)
      !$onehot0(~ras_n_o) |-> bus_i.refresh && bus_i.aen);

endmodule

`default_nettype wire

// File: design/mb_hold_ctrl.sv
// ----------------------------------------------------------
// Hold-acknowledge chain handing the bus to the DMA controller
// Grant waits for a passive CPU status and no bus lock
// hrq_i has to stay high until the bus enable has risen
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mb_hold_ctrl (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       hrq_i,
   input  logic [2:0] status_n_i,
   input  logic       lock_n_i,
   output logic       holda_o,
   output logic       aen_brd_o,
   output logic       dma_aen_o
);

   logic idle_req;
   logic idle_q;
   logic holda_q;
   logic aen_q;
   logic dma_q;

   // Passive status means the CPU is between bus cycles
   assign idle_req = hrq_i && (status_n_i == 3'b111) && lock_n_i;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         idle_q  <= 1'b0;
         holda_q <= 1'b0;
         aen_q   <= 1'b0;
         dma_q   <= 1'b0;
      end else begin
         idle_q <= idle_req;

         if (!hrq_i)
            holda_q <= 1'b0;   // Release starts right away
         else if (idle_q)
            holda_q <= 1'b1;   // Held until the request drops

         aen_q <= holda_q;
         dma_q <= aen_q;   // DMA address drivers enable last
      end
   end

   assign holda_o   = holda_q;
   assign aen_brd_o = aen_q;
   assign dma_aen_o = dma_q;

   // Bus enable only takes effect under a live acknowledge
   a_aen_under_holda: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(aen_brd_o) |-> holda_o);

endmodule

`default_nettype wire

// File: design/mb_nmi_ctrl.sv
// ----------------------------------------------------------
// NMI mask register and I/O channel-check latch
// nmi_o lags its cause by one clock
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mb_nmi_ctrl (
   input  logic             clk,
   input  logic             reset_n,
   input  mb_pkg::mb_data_t data_i,
   input  logic             nmi_mask_wr_i,
   input  logic             pck_i,
   input  logic             io_ch_ck_n_i,
   input  logic             enable_io_ck_n_i,
   output logic             nmi_o
);

   logic mask_q;
   logic chk_q;
   logic pck_q;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mask_q <= 1'b0;
         chk_q  <= 1'b0;
         pck_q  <= 1'b0;
      end else begin
         if (nmi_mask_wr_i)
            mask_q <= data_i[7];   // Bit 7 enables NMI
         if (enable_io_ck_n_i)
            chk_q <= 1'b0;
         else if (!io_ch_ck_n_i)
            chk_q <= 1'b1;
         pck_q <= pck_i;
      end
   end

   assign nmi_o = mask_q && (pck_q || chk_q);

endmodule

`default_nettype wire

// File: design/motherboard_glue.sv
// ----------------------------------------------------------
// System-board glue for an 8088 PC on a single clock
// Board command pins are active low, bus enables active high
// Decoded outputs appear one cycle after the bus pins
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mb_config.svh"

module motherboard_glue (
   input  logic                      clk,
   input  logic                      reset_n,
   input  mb_pkg::mb_addr_t          cpu_addr_i,
   input  logic                      ale_i,
   input  logic                      ior_n_i,
   input  logic                      iow_n_i,
   input  logic                      memr_n_i,
   input  logic                      memw_n_i,
   input  logic [2:0]                status_n_i,
   input  logic                      lock_n_i,
   input  logic                      hrq_i,
   input  logic [`MB_DMA_ADDR_W-1:0] dma_addr_i,
   input  logic [`MB_DMA_CHANS-1:0]  dack_n_i,
   input  mb_pkg::mb_data_t          data_i,
   input  logic                      pck_i,
   input  logic                      io_ch_ck_n_i,
   input  logic                      enable_io_ck_n_i,
   output logic [`MB_IO_CS_W-1:0]    io_cs_n_o,
   output logic [`MB_ROM_SELS-1:0]   rom_cs_n_o,
   output mb_pkg::mb_bank_t          ras_n_o,
   output mb_pkg::mb_bank_t          cas_n_o,
   output logic                      addr_sel_o,
   output logic                      holda_o,
   output logic                      aen_o,
   output logic                      dma_aen_n_o,
   output logic                      nmi_o
);

   logic page_wr;
   logic nmi_mask_wr;
   logic aen_brd;
   logic dma_aen;

   mb_sys_bus_if sys_bus ();

   mb_addr_former u_addr_former (
      .clk        (clk),
      .reset_n    (reset_n),
      .cpu_addr_i (cpu_addr_i),
      .ale_i      (ale_i),
      .dma_addr_i (dma_addr_i),
      .dack_n_i   (dack_n_i),
      .ior_n_i    (ior_n_i),
      .iow_n_i    (iow_n_i),
      .memr_n_i   (memr_n_i),
      .memw_n_i   (memw_n_i),
      .data_i     (data_i),
      .page_wr_i  (page_wr),
      .aen_brd_i  (aen_brd),
      .dma_aen_i  (dma_aen),
      .bus_o      (sys_bus)
   );

   mb_io_decoder u_io_decoder (
      .bus_i         (sys_bus),
      .io_cs_n_o     (io_cs_n_o),
      .page_wr_o     (page_wr),
      .nmi_mask_wr_o (nmi_mask_wr)
   );

   mb_mem_decoder u_mem_decoder (
      .clk        (clk),
      .reset_n    (reset_n),
      .bus_i      (sys_bus),
      .rom_cs_n_o (rom_cs_n_o),
      .ras_n_o    (ras_n_o),
      .cas_n_o    (cas_n_o),
      .addr_sel_o (addr_sel_o)
   );

   mb_hold_ctrl u_hold_ctrl (
      .clk        (clk),
      .reset_n    (reset_n),
      .hrq_i      (hrq_i),
      .status_n_i (status_n_i),
      .lock_n_i   (lock_n_i),
      .holda_o    (holda_o),
      .aen_brd_o  (aen_brd),
      .dma_aen_o  (dma_aen)
   );

   mb_nmi_ctrl u_nmi_ctrl (
      .clk              (clk),
      .reset_n          (reset_n),
      .data_i           (data_i),
      .nmi_mask_wr_i    (nmi_mask_wr),
      .pck_i            (pck_i),
      .io_ch_ck_n_i     (io_ch_ck_n_i),
      .enable_io_ck_n_i (enable_io_ck_n_i),
      .nmi_o            (nmi_o)
   );

   assign aen_o       = aen_brd;
   assign dma_aen_n_o = ~dma_aen;   // Board pin is active low

endmodule

`default_nettype wire

// File: bench/motherboard_glue_tb.sv
// ----------------------------------------------------------
// Self-checking testbench for the motherboard glue logic
// Inputs change 1 ns after the rising edge and outputs are
// compared on the falling edge against reference functions
// Page entries stay below 256 KB so DMA cycles reach RAM
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "mb_config.svh"

module motherboard_glue_tb;

   logic             clk;
   logic             reset_n;
   mb_pkg::mb_addr_t cpu_addr_i;
   logic             ale_i;
   logic             ior_n_i;
   logic             iow_n_i;
   logic             memr_n_i;
   logic             memw_n_i;
   logic [2:0]       status_n_i;
   logic             lock_n_i;
   logic             hrq_i;
   logic [15:0]      dma_addr_i;
   logic [3:0]       dack_n_i;
   logic [7:0]       data_i;
   logic             pck_i;
   logic             io_ch_ck_n_i;
   logic             enable_io_ck_n_i;
   logic [3:0]       io_cs_n_o;
   logic [7:0]       rom_cs_n_o;
   logic [3:0]       ras_n_o;
   logic [3:0]       cas_n_o;
   logic             addr_sel_o;
   logic             holda_o;
   logic             aen_o;
   logic             dma_aen_n_o;
   logic             nmi_o;

   logic             chk_io;
   logic             chk_mem;
   logic             chk_hold;
   logic             chk_nmi;
   logic [3:0]       exp_io;
   logic [16:0]      exp_mem;    // rom, ras, cas, addr_sel
   logic [2:0]       exp_hold;   // holda, aen, dma_aen_n
   logic             exp_nmi;
   string            mem_name;
   int               n_checks;
   int               n_errors;
   logic [3:0]       page_model [4];

   motherboard_glue u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [3:0] port_ref(input logic [9:0] port);
      logic [3:0] cs;
      cs = 4'hF;
      if (port[9:8] == 2'b00 && port[7:5] < 3'd4)
         cs[port[6:5]] = 1'b0;   // Groups 0 to 3 have a chip select
      return cs;
   endfunction

   function automatic logic [16:0] mem_ref(input logic [19:0] a, input logic rd,
                                            input logic wr, input logic refr,
                                            input logic late);
      logic [7:0] rom;
      logic [3:0] ras;
      logic [3:0] cas;
      logic       normal;
      normal = (rd || wr) && !refr && (a < 20'h40000);
      rom = 8'hFF;
      if (rd && a[19:16] == `MB_ROM_SEGMENT)
         rom[a[15:13]] = 1'b0;
      ras = 4'hF;
      if (rd && refr)
         ras = 4'h0;   // Every bank refreshed
      else if (normal)
         ras[a[17:16]] = 1'b0;
      cas = (normal && late) ? ras : 4'hF;
      return {rom, ras, cas, normal && late};
   endfunction

   // Edges since the request and since its release, rel is 0 while requested
   function automatic logic [2:0] hold_ref(input int req, input int rel);
      return {req >= 2 && rel < 1, req >= 3 && rel < 2, !(req >= 4 && rel < 3)};
   endfunction

   function automatic logic nmi_ref(input logic mask, input logic pck, input logic chk);
      return mask && (pck || chk);
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      n_checks++;
      assert (actual === expected)
      else begin
         n_errors++;
         $display("Error in %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic io_write(input logic [9:0] port, input logic [7:0] data);
      cpu_addr_i = {10'b0, port};
      ale_i = 1'b1;
      iow_n_i = 1'b0;
      data_i = data;
      next_cycle();
      ale_i = 1'b0;
      next_cycle();
      iow_n_i = 1'b1;   // Data held until the strobe has gone
      next_cycle();
   endtask

   task automatic wait_hold_pin(input bit use_holda, input logic lvl, output int edges);
      logic pin;
      edges = 0;
      pin = use_holda ? holda_o : dma_aen_n_o;
      while (pin !== lvl) begin
         if (edges == 16) begin
            $display("Timeout while waiting for the hold handshake to reach %b", lvl);
            $display("test failed");
            $finish;
         end else begin
            next_cycle();
            edges++;
            pin = use_holda ? holda_o : dma_aen_n_o;
         end
      end
   endtask

   task automatic grant_bus();
      int edges;
      hrq_i = 1'b1;
      wait_hold_pin(1'b0, 1'b0, edges);   // DMA address enable active
   endtask

   task automatic release_bus();
      int edges;
      hrq_i = 1'b0;
      wait_hold_pin(1'b0, 1'b1, edges);
   endtask

   always @(negedge clk) begin
      if (chk_io)
         compare("port decode", exp_io, io_cs_n_o);
      if (chk_mem)
         compare(mem_name, exp_mem, {rom_cs_n_o, ras_n_o, cas_n_o, addr_sel_o});
      if (chk_hold)
         compare("hold sequence", exp_hold, {holda_o, aen_o, dma_aen_n_o});
      if (chk_nmi)
         compare("nmi", exp_nmi, nmi_o);
   end

   initial begin
      int          rnd;
      int          edges;
      logic [9:0]  port;
      logic [19:0] addr;
      logic [7:0]  data;
      logic        rd;
      logic        mask;

      rnd = $urandom(32'h82a3);
      reset_n = 1'b0;
      cpu_addr_i = '0;
      ale_i = 1'b0;
      ior_n_i = 1'b1;
      iow_n_i = 1'b1;
      memr_n_i = 1'b1;
      memw_n_i = 1'b1;
      status_n_i = 3'b111;   // Passive CPU status
      lock_n_i = 1'b1;
      hrq_i = 1'b0;
      dma_addr_i = '0;
      dack_n_i = 4'hF;
      data_i = '0;
      pck_i = 1'b0;
      io_ch_ck_n_i = 1'b1;
      enable_io_ck_n_i = 1'b1;
      chk_io = 1'b0;
      chk_mem = 1'b0;
      chk_hold = 1'b0;
      chk_nmi = 1'b0;
      n_checks = 0;
      n_errors = 0;
      mem_name = "memory decode";
      for (int i = 0; i < 4; i++)
         page_model[i] = '0;
      repeat (8) @(posedge clk);
      #1;
      reset_n = 1'b1;
      next_cycle();

      // Port decoding, half of the ports in the decoded range
      for (int i = 0; i < 24; i++) begin
         port = 10'($urandom);
         if (i % 2 == 0)
            port[9:8] = 2'b00;
         cpu_addr_i = {10'b0, port};
         ale_i = 1'b1;
         ior_n_i = 1'b0;
         next_cycle();
         ale_i = 1'b0;
         exp_io = port_ref(port);
         chk_io = 1'b1;
         next_cycle();
         chk_io = 1'b0;
         ior_n_i = 1'b1;
      end

      // Memory decoding, biased towards ROM and RAM
      for (int i = 0; i < 30; i++) begin
         addr = 20'($urandom);
         if (i % 3 == 0)
            addr[19:16] = `MB_ROM_SEGMENT;
         else if (i % 3 == 1)
            addr[19:18] = 2'b00;
         rd = 1'($urandom);
         cpu_addr_i = addr;
         ale_i = 1'b1;
         memr_n_i = !rd;
         memw_n_i = rd;
         next_cycle();
         ale_i = 1'b0;
         exp_mem = mem_ref(addr, rd, !rd, 1'b0, 1'b0);
         chk_mem = 1'b1;
         next_cycle();
         exp_mem = mem_ref(addr, rd, !rd, 1'b0, 1'b1);   // Column phase
         next_cycle();
         chk_mem = 1'b0;
         memr_n_i = 1'b1;
         memw_n_i = 1'b1;
         next_cycle();
      end

      // Hold grant and release with an idle CPU
      hrq_i = 1'b1;
      for (int k = 1; k <= 6; k++) begin
         next_cycle();
         exp_hold = hold_ref(k, 0);
         chk_hold = 1'b1;
      end
      hrq_i = 1'b0;
      for (int k = 1; k <= 4; k++) begin
         next_cycle();
         exp_hold = hold_ref(6, k);
      end
      lock_n_i = 1'b0;   // Locked bus holds the request off
      hrq_i = 1'b1;
      for (int k = 1; k <= 5; k++) begin
         next_cycle();
         exp_hold = hold_ref(0, 0);
      end
      chk_hold = 1'b0;
      lock_n_i = 1'b1;
      wait_hold_pin(1'b1, 1'b1, edges);
      compare("lock release", 2, edges);
      wait_hold_pin(1'b0, 1'b0, edges);
      release_bus();

      // Page entries, then DMA cycles with refresh on channel 0
      for (int ch = 0; ch < 4; ch++) begin
         data = 8'($urandom) & 8'hF3;
         io_write(10'h080 | 10'(ch), data);
         page_model[ch] = data[3:0];
      end
      grant_bus();
      for (int ch = 0; ch < 4; ch++) begin
         rd = (ch == 0);
         dack_n_i = ~(4'b0001 << ch);
         dma_addr_i = 16'($urandom);
         memr_n_i = !rd;
         memw_n_i = rd;
         addr = {page_model[ch], dma_addr_i};
         next_cycle();
         mem_name = rd ? "refresh" : "page register";
         exp_mem = mem_ref(addr, rd, !rd, rd, 1'b0);
         chk_mem = 1'b1;
         next_cycle();
         exp_mem = mem_ref(addr, rd, !rd, rd, 1'b1);
         next_cycle();
         chk_mem = 1'b0;
         dack_n_i = 4'hF;
         memr_n_i = 1'b1;
         memw_n_i = 1'b1;
         next_cycle();
      end
      release_bus();

      // NMI mask, parity and channel check
      for (int i = 0; i < 8; i++) begin
         data = 8'($urandom);
         mask = data[7];
         io_write(10'h0A0 | 10'($urandom % 32), data);
         pck_i = 1'b1;
         next_cycle();
         exp_nmi = nmi_ref(mask, 1'b1, 1'b0);
         chk_nmi = 1'b1;
         pck_i = 1'b0;
         next_cycle();
         exp_nmi = nmi_ref(mask, 1'b0, 1'b0);
         io_ch_ck_n_i = 1'b0;
         enable_io_ck_n_i = 1'b0;
         next_cycle();
         exp_nmi = nmi_ref(mask, 1'b0, 1'b1);
         io_ch_ck_n_i = 1'b1;   // Latch keeps the check
         next_cycle();
         enable_io_ck_n_i = 1'b1;
         next_cycle();
         exp_nmi = nmi_ref(mask, 1'b0, 1'b0);
         next_cycle();
         chk_nmi = 1'b0;
      end

      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: motherboard_glue.f
+incdir+include
design/mb_pkg.sv
design/mb_sys_bus_if.sv
design/mb_addr_former.sv
design/mb_io_decoder.sv
design/mb_mem_decoder.sv
design/mb_hold_ctrl.sv
design/mb_nmi_ctrl.sv
design/motherboard_glue.sv
bench/motherboard_glue_tb.sv

// File: Bender.yml
package:
  name: motherboard_glue

sources:
  - include_dirs:
      - include
    files:
      - design/mb_pkg.sv
      - design/mb_sys_bus_if.sv
      - design/mb_addr_former.sv
      - design/mb_io_decoder.sv
      - design/mb_mem_decoder.sv
      - design/mb_hold_ctrl.sv
      - design/mb_nmi_ctrl.sv
      - design/motherboard_glue.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/motherboard_glue_tb.sv
